// ==== all.f ====
hw/opb_wb_pkg.sv
hw/opb_wb_attach.sv
hw/wb_addr_decode.sv
hw/wb_reg_bank.sv
hw/opb_wb_subsys.sv
sim/tb_clk_gen.sv
sim/opb_wb_chk.sv
sim/opb_wb_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

obj_dir="obj_dir"
sim_bin="opb_wb_sim"
log_file="sim.log"

# build the simulation model with the testbench as top
verilator --binary --timing --assert \
  --top-module opb_wb_tb \
  -Mdir "$obj_dir" -o "$sim_bin" \
  -f all.f
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

# run it and keep the output for the pass search
"./$obj_dir/$sim_bin" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx 'All tests passed!' "$log_file"; then
  echo "simulation passed"
  exit 0
fi

echo "pass message not found in $log_file"
exit 1

// ==== sim/opb_wb_tb.sv ====
`timescale 1ns/10ps

module opb_wb_tb
  import opb_wb_pkg::*;
();

  localparam int total_words  = int'(bank0_words + bank1_words);
  localparam int reset_cycles = 8;
  localparam int max_wait     = 4;

  typedef enum logic [1:0] {
    kind_ack,
    kind_err,
    kind_noack
  } kind_e;

  // one row of the transfer table, exp_dat comes from the shadow model
  typedef struct packed {
    logic              rnw;
    logic [31:0]       addr;
    logic [bus_bw-1:0] be;
    logic [31:0]       wdat;
    kind_e             kind;
    logic [31:0]       exp_dat;
  } xfer_t;

  logic              OPB_Clk;
  logic              rst;
  logic              opb_rnw;
  logic              opb_select;
  logic [bus_bw-1:0] opb_be;
  logic [31:0]       opb_abus;
  logic [bus_dw-1:0] opb_dbus;
  logic [bus_dw-1:0] sl_dbus;
  logic              sl_xfer_ack;
  logic              sl_err_ack;
  logic              sl_retry;
  logic              sl_tout_sup;

  xfer_t       xfers[$];
  logic [31:0] shadow [total_words];
  logic        table_ready = 1'b0;
  int          checks;
  int          value_errors;
  int          handshake_errors;

  tb_clk_gen u_clk_gen (
    .clk_o (OPB_Clk)
  );

  opb_wb_subsys i_dut (
    .OPB_Clk       (OPB_Clk),
    .rst_i         (rst),
    .opb_rnw_i     (opb_rnw),
    .opb_select_i  (opb_select),
    .opb_be_i      (opb_be),
    .opb_abus_i    (opb_abus),
    .opb_dbus_i    (opb_dbus),
    .sl_dbus_o     (sl_dbus),
    .sl_xfer_ack_o (sl_xfer_ack),
    .sl_err_ack_o  (sl_err_ack),
    .sl_retry_o    (sl_retry),
    .sl_tout_sup_o (sl_tout_sup)
  );

  bind opb_wb_attach opb_wb_chk u_chk (
    .OPB_Clk       (OPB_Clk),
    .rst_i         (rst_i),
    .wb_stb_i      (wb_stb_o),
    .sl_xfer_ack_i (sl_xfer_ack_o),
    .sl_err_ack_i  (sl_err_ack_o),
    .sl_retry_i    (sl_retry_o),
    .sl_tout_sup_i (sl_tout_sup_o)
  );

  // shadow word for an offset, bank 1 words follow the bank 0 words
  function automatic int shadow_index(input logic [31:0] off);
    if (off >= bank0_offset && off < bank0_offset + 32'(bank0_words * bus_bw)) begin
      return int'((off - bank0_offset) >> 2);
    end
    if (off >= bank1_offset && off < bank1_offset + 32'(bank1_words * bus_bw)) begin
      return int'(bank0_words) + int'((off - bank1_offset) >> 2);
    end
    return -1;
  endfunction

  function automatic logic [31:0] word_addr(input int w);
    if (w < int'(bank0_words)) begin
      return opb_base_addr + bank0_offset + 32'(4 * w);
    end
    return opb_base_addr + bank1_offset + 32'(4 * (w - int'(bank0_words)));
  endfunction

  task automatic add_row(input logic rnw, input logic [31:0] addr,
                         input logic [bus_bw-1:0] be, input logic [31:0] wdat,
                         input kind_e kind);
    xfer_t row;
    int    idx;
    row.rnw     = rnw;
    row.addr    = addr;
    row.be      = be;
    row.wdat    = wdat;
    row.kind    = kind;
    row.exp_dat = '0;
    idx = shadow_index(addr - opb_base_addr);
    // only acknowledged transfers read or change a bank
    if (kind == kind_ack && idx >= 0) begin
      if (rnw) begin
        row.exp_dat = shadow[idx];
      end else begin
        for (int b = 0; b < bus_bw; b++) begin
          if (be[b]) begin
            shadow[idx][8*b +: 8] = wdat[8*b +: 8];
          end
        end
      end
    end
    xfers.push_back(row);
  endtask

  task automatic build_table();
    logic [bus_bw-1:0] be_list [8];
    logic [31:0]       bad_addr [4];
    logic [31:0]       addr;
    be_list  = '{4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'hc, 4'h5, 4'ha};
    bad_addr = '{32'h7fff_fffc, 32'h8000_0100, 32'h0000_0040, 32'hffff_fffc};
    // every word reads zero after reset
    for (int w = 0; w < total_words; w++) begin
      add_row(1'b1, word_addr(w), '1, '0, kind_ack);
    end
    // full word writes, then read back
    for (int w = 0; w < total_words; w++) begin
      add_row(1'b0, word_addr(w), '1, $urandom, kind_ack);
    end
    for (int w = 0; w < total_words; w++) begin
      add_row(1'b1, word_addr(w), '1, '0, kind_ack);
    end
    // partial byte lanes over both banks
    for (int k = 0; k < 8; k++) begin
      add_row(1'b0, word_addr((k * 5) % total_words), be_list[k], $urandom, kind_ack);
    end
    for (int k = 0; k < 8; k++) begin
      add_row(1'b1, word_addr((k * 5) % total_words), '1, '0, kind_ack);
    end
    // unmapped offsets 0x60 up to 0xfc
    for (int k = 0; k < 9; k++) begin
      addr = (k == 8) ? opb_base_addr + 32'hfc : opb_base_addr + 32'h60 + 32'(k * 20);
      add_row(1'b0, addr, '1, $urandom, kind_err);
      add_row(1'b1, addr, '1, '0, kind_err);
    end
    // banks must be untouched by the unmapped writes
    for (int w = 0; w < total_words; w++) begin
      add_row(1'b1, word_addr(w), '1, '0, kind_ack);
    end
    // outside the window, each followed by a normal read
    for (int k = 0; k < 4; k++) begin
      add_row((k % 2) == 1, bad_addr[k], '1, $urandom, kind_noack);
      add_row(1'b1, word_addr(k * 7), '1, '0, kind_ack);
    end
  endtask

  task automatic check_value(input string what, input logic [31:0] addr,
                             input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      value_errors++;
      $display("[ERROR] %0t: %s at address %h is %h, expected %h",
               $time, what, addr, got, exp);
    end
  endtask

  task automatic check_handshake(input logic ok, input string msg, input logic [31:0] addr);
    checks++;
    assert (ok) else begin
      handshake_errors++;
      $display("[ERROR] %0t: %s (address %h)", $time, msg, addr);
    end
  endtask

  task automatic apply_row(input xfer_t row);
    int          ack_cycle;
    logic        ack_err;
    logic [31:0] ack_dat;
    ack_cycle = -1;
    ack_err   = 1'b0;
    ack_dat   = '0;
    @(posedge OPB_Clk);
    opb_select <= 1'b1;
    opb_rnw    <= row.rnw;
    opb_abus   <= row.addr;
    opb_be     <= row.be;
    opb_dbus   <= row.rnw ? '0 : row.wdat;
    // sample mid cycle, outputs change only on the rising edge
    for (int c = 0; c < max_wait && ack_cycle < 0; c++) begin
      @(negedge OPB_Clk);
      // retry and timeout suppression are never used by this slave
      check_value("Sl_retry", row.addr, 32'(sl_retry), '0);
      check_value("Sl_toutSup", row.addr, 32'(sl_tout_sup), '0);
      if (sl_xfer_ack) begin
        ack_cycle = c;
        ack_err   = sl_err_ack;
        ack_dat   = sl_dbus;
      end else begin
        check_value("Sl_DBus without ack", row.addr, sl_dbus, '0);
        check_value("Sl_errAck without ack", row.addr, 32'(sl_err_ack), '0);
      end
    end
    if (row.kind == kind_noack) begin
      check_handshake(ack_cycle < 0, "acknowledge seen for an address outside the window",
                      row.addr);
    end else begin
      check_handshake(ack_cycle >= 0, "no acknowledge within four cycles", row.addr);
      if (ack_cycle >= 0) begin
        check_handshake(ack_cycle == 1, "acknowledge not one cycle after select", row.addr);
        check_value("Sl_errAck", row.addr, 32'(ack_err), 32'(row.kind == kind_err));
        check_value("Sl_DBus", row.addr, ack_dat, row.exp_dat);
      end
    end
    // master drops select for a cycle before the next transfer
    @(posedge OPB_Clk);
    opb_select <= 1'b0;
    opb_rnw    <= 1'b1;
    opb_abus   <= '0;
    opb_be     <= '0;
    opb_dbus   <= '0;
    @(negedge OPB_Clk);
    check_handshake(!sl_xfer_ack, "acknowledge held for more than one cycle", row.addr);
    check_value("Sl_DBus after ack", row.addr, sl_dbus, '0);
  endtask

  initial begin
    void'($urandom(84));
    rst        <= 1'b1;
    opb_select <= 1'b0;
    opb_rnw    <= 1'b1;
    opb_abus   <= '0;
    opb_be     <= '0;
    opb_dbus   <= '0;
    checks           = 0;
    value_errors     = 0;
    handshake_errors = 0;
    for (int w = 0; w < total_words; w++) begin
      shadow[w] = '0;
    end
    build_table();
    table_ready = 1'b1;
    repeat (reset_cycles) @(posedge OPB_Clk);
    rst <= 1'b0;
    foreach (xfers[i]) begin
      apply_row(xfers[i]);
    end
    repeat (2) @(posedge OPB_Clk);
    $display("checks: %0d, value errors: %0d, handshake errors: %0d",
             checks, value_errors, handshake_errors);
    if (value_errors + handshake_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // a transfer needs at most about six cycles, allow ten per row
  initial begin
    int limit_cycles;
    wait (table_ready);
    limit_cycles = reset_cycles + 10 * xfers.size() + 50;
    repeat (limit_cycles) @(posedge OPB_Clk);
    $display("timeout: the run did not finish within %0d cycles", limit_cycles);
    $display("Test failures found");
    $finish;
  end

endmodule

// ==== sim/opb_wb_chk.sv ====
`timescale 1ns/10ps

module opb_wb_chk (
  input logic OPB_Clk,
  input logic rst_i,
  input logic wb_stb_i,
  input logic sl_xfer_ack_i,
  input logic sl_err_ack_i,
  input logic sl_retry_i,
  input logic sl_tout_sup_i
);

  // acknowledge is a single cycle pulse
  ack_single: assert property (@(posedge OPB_Clk) disable iff (rst_i)
    sl_xfer_ack_i |=> !sl_xfer_ack_i)
    else $error("Sl_xferAck high for two cycles in a row");

  // error acknowledge never comes alone
  err_with_ack: assert property (@(posedge OPB_Clk) disable iff (rst_i)
    sl_err_ack_i |-> sl_xfer_ack_i)
    else $error("Sl_errAck high without Sl_xferAck");

  // every wishbone strobe is answered in the next cycle
  stb_then_ack: assert property (@(posedge OPB_Clk) disable iff (rst_i)
    wb_stb_i |=> sl_xfer_ack_i)
    else $error("strobe not followed by an acknowledge");

  tied_low: assert property (@(posedge OPB_Clk) disable iff (rst_i)
    !sl_retry_i && !sl_tout_sup_i)
    else $error("Sl_retry or Sl_toutSup went high");

endmodule

// ==== sim/tb_clk_gen.sv ====
`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk_o
);

  // 20 ns period
  localparam int half_period_ns = 10;

  initial begin
    clk_o = 1'b0;
  end

  always begin
    #(half_period_ns) clk_o = ~clk_o;
  end

endmodule

// ==== hw/opb_wb_subsys.sv ====
`timescale 1ns/10ps

module opb_wb_subsys
  import opb_wb_pkg::*;
(
  input  logic              OPB_Clk,
  input  logic              rst_i,
  input  logic              opb_rnw_i,
  input  logic              opb_select_i,
  input  logic [bus_bw-1:0] opb_be_i,
  input  logic [31:0]       opb_abus_i,
  input  logic [bus_dw-1:0] opb_dbus_i,
  output logic [bus_dw-1:0] sl_dbus_o,
  output logic              sl_xfer_ack_o,
  output logic              sl_err_ack_o,
  output logic              sl_retry_o,
  output logic              sl_tout_sup_o
);

  logic              wb_stb;
  wb_req_t           wb_req;
  wb_rsp_t           wb_rsp;
  logic              bank0_stb;
  logic              bank1_stb;
  logic [bus_dw-1:0] bank0_dat;
  logic [bus_dw-1:0] bank1_dat;

  opb_wb_attach u_attach (
    .OPB_Clk       (OPB_Clk),
    .rst_i         (rst_i),
    .opb_rnw_i     (opb_rnw_i),
    .opb_select_i  (opb_select_i),
    .opb_be_i      (opb_be_i),
    .opb_abus_i    (opb_abus_i),
    .opb_dbus_i    (opb_dbus_i),
    .wb_rsp_i      (wb_rsp),
    .wb_stb_o      (wb_stb),
    .wb_req_o      (wb_req),
    .sl_dbus_o     (sl_dbus_o),
    .sl_xfer_ack_o (sl_xfer_ack_o),
    .sl_err_ack_o  (sl_err_ack_o),
    .sl_retry_o    (sl_retry_o),
    .sl_tout_sup_o (sl_tout_sup_o)
  );

  wb_addr_decode u_decode (
    .wb_stb_i    (wb_stb),
    .wb_req_i    (wb_req),
    .bank0_dat_i (bank0_dat),
    .bank1_dat_i (bank1_dat),
    .bank0_stb_o (bank0_stb),
    .bank1_stb_o (bank1_stb),
    .wb_rsp_o    (wb_rsp)
  );

  // both banks share the request, the decoder picks one by strobe
  wb_reg_bank #(.depth(bank0_words)) u_bank0 (
    .OPB_Clk  (OPB_Clk),
    .rst_i    (rst_i),
    .wb_stb_i (bank0_stb),
    .wb_req_i (wb_req),
    .wb_dat_o (bank0_dat)
  );

  wb_reg_bank #(.depth(bank1_words)) u_bank1 (
    .OPB_Clk  (OPB_Clk),
    .rst_i    (rst_i),
    .wb_stb_i (bank1_stb),
    .wb_req_i (wb_req),
    .wb_dat_o (bank1_dat)
  );

endmodule

// ==== hw/wb_reg_bank.sv ====
`timescale 1ns/10ps

module wb_reg_bank
  import opb_wb_pkg::*;
#(
  parameter int unsigned depth = 16
) (
  input  logic              OPB_Clk,
  input  logic              rst_i,
  input  logic              wb_stb_i,
  input  wb_req_t           wb_req_i,
  output logic [bus_dw-1:0] wb_dat_o
);

  logic [bus_dw-1:0]        regs [depth];
  logic [$clog2(depth)-1:0] word_idx;

  // word index, byte address bits below the lane count are dropped
  assign word_idx = wb_req_i.adr[$clog2(depth)+1:2];

  always_ff @(posedge OPB_Clk) begin
    if (rst_i) begin
      for (int w = 0; w < depth; w++) begin
        regs[w] <= '0;
      end
    end else if (wb_stb_i && wb_req_i.we) begin
      // only lanes with their select bit set are written
      for (int b = 0; b < bus_bw; b++) begin
        if (wb_req_i.sel[b]) begin
          regs[word_idx][8*b +: 8] <= wb_req_i.dat[8*b +: 8];
        end
      end
    end
  end

  // combinational read, the bridge samples it in the strobe cycle
  assign wb_dat_o = regs[word_idx];

endmodule

// ==== hw/wb_addr_decode.sv ====
`timescale 1ns/10ps

module wb_addr_decode
  import opb_wb_pkg::*;
(
  input  logic              wb_stb_i,
  input  wb_req_t           wb_req_i,
  input  logic [bus_dw-1:0] bank0_dat_i,
  input  logic [bus_dw-1:0] bank1_dat_i,
  output logic              bank0_stb_o,
  output logic              bank1_stb_o,
  output wb_rsp_t           wb_rsp_o
);

  logic bank0_hit;
  logic bank1_hit;
  logic unmapped;

  // each bank covers words * byte lanes bytes from its offset
  always_comb begin
    bank0_hit = (wb_req_i.adr >= bank0_offset) &&
                (wb_req_i.adr <  bank0_offset + bank0_words * bus_bw);
    bank1_hit = (wb_req_i.adr >= bank1_offset) &&
                (wb_req_i.adr <  bank1_offset + bank1_words * bus_bw);
  end

  assign unmapped = !bank0_hit && !bank1_hit;

  // at most one bank sees the strobe, so unmapped writes are dropped
  assign bank0_stb_o = wb_stb_i && bank0_hit;
  assign bank1_stb_o = wb_stb_i && bank1_hit && !bank0_hit;

  // read data back from the addressed bank
  always_comb begin
    if (bank0_hit) begin
      wb_rsp_o.dat = bank0_dat_i;
    end else if (bank1_hit) begin
      wb_rsp_o.dat = bank1_dat_i;
    end else begin
      wb_rsp_o.dat = '0;
    end
  end

  // bus error only for a strobed access that matched no bank
  assign wb_rsp_o.err = wb_stb_i && unmapped;

endmodule

// ==== hw/opb_wb_attach.sv ====
`timescale 1ns/10ps

module opb_wb_attach
  import opb_wb_pkg::*;
(
  input  logic              OPB_Clk,
  input  logic              rst_i,
  input  logic              opb_rnw_i,
  input  logic              opb_select_i,
  input  logic [bus_bw-1:0] opb_be_i,
  input  logic [31:0]       opb_abus_i,
  input  logic [bus_dw-1:0] opb_dbus_i,
  input  wb_rsp_t           wb_rsp_i,
  output logic              wb_stb_o,
  output wb_req_t           wb_req_o,
  output logic [bus_dw-1:0] sl_dbus_o,
  output logic              sl_xfer_ack_o,
  output logic              sl_err_ack_o,
  output logic              sl_retry_o,
  output logic              sl_tout_sup_o
);

  logic              select_q;
  logic              in_window;
  logic              xfer_ack_q;
  logic              err_ack_q;
  logic [bus_dw-1:0] rd_dat_q;

  // previous select level, used to find the first cycle of a transfer
  always_ff @(posedge OPB_Clk) begin
    if (rst_i) begin
      select_q <= 1'b0;
    end else begin
      select_q <= opb_select_i;
    end
  end

  assign in_window = (opb_abus_i >= opb_base_addr) && (opb_abus_i <= opb_high_addr);

  // single strobe on the rising edge of select
  assign wb_stb_o = opb_select_i && !select_q && in_window;

  assign wb_req_o.we  = ~opb_rnw_i;
  assign wb_req_o.sel = opb_be_i;
  assign wb_req_o.adr = opb_abus_i - opb_base_addr;
  assign wb_req_o.dat = opb_dbus_i;

  // response is sampled at the end of the strobe cycle and shown for one clock
  always_ff @(posedge OPB_Clk) begin
    if (rst_i) begin
      xfer_ack_q <= 1'b0;
      err_ack_q  <= 1'b0;
      rd_dat_q   <= '0;
    end else begin
      xfer_ack_q <= wb_stb_o;
      err_ack_q  <= wb_stb_o && wb_rsp_i.err;
      // the OPB data bus is or-ed, keep it at zero outside read acks
      if (wb_stb_o && opb_rnw_i) begin
        rd_dat_q <= wb_rsp_i.dat;
      end else begin
        rd_dat_q <= '0;
      end
    end
  end

  assign sl_xfer_ack_o = xfer_ack_q;
  assign sl_err_ack_o  = err_ack_q;
  assign sl_dbus_o     = rd_dat_q;

  // no retry and no timeout suppression in this slave
  assign sl_retry_o    = 1'b0;
  assign sl_tout_sup_o = 1'b0;

endmodule

// ==== hw/opb_wb_pkg.sv ====
package opb_wb_pkg;

  // OPB window claimed by the peripheral
  localparam logic [31:0] opb_base_addr = 32'h8000_0000;
  localparam logic [31:0] opb_high_addr = 32'h8000_00ff;

  // data path width and number of byte lanes
  localparam int unsigned bus_dw = 32;
  localparam int unsigned bus_bw = bus_dw / 8;

  // register bank map, offsets are relative to opb_base_addr
  localparam logic [31:0] bank0_offset = 32'h0000_0000;
  localparam int unsigned bank0_words  = 16;

  localparam logic [31:0] bank1_offset = 32'h0000_0040;
  localparam int unsigned bank1_words  = 8;

  // offsets 0x60 up to 0xff belong to no bank and answer with an error

  // one wishbone request, valid while the strobe is high
  typedef struct packed {
    logic              we;
    logic [bus_bw-1:0] sel;
    logic [31:0]       adr;
    logic [bus_dw-1:0] dat;
  } wb_req_t;

  // slaves are zero wait state, so no ack field is carried
  typedef struct packed {
    logic [bus_dw-1:0] dat;
    logic              err;
  } wb_rsp_t;

endpackage
